//--- verilog/csr_pkg.sv
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // Machine interrupt lines, index into the 3-bit enable and pending vectors
    localparam int NUM_IRQ   = 3;
    localparam int IRQ_SOFT  = 0;
    localparam int IRQ_TIMER = 1;
    localparam int IRQ_EXT   = 2;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_mode_e;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_W     = 3'd1,
        CMD_S     = 3'd2,
        CMD_C     = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_e;

    typedef enum logic [CSR_ADDR_W-1:0] {
        MSTATUS  = 12'h300,
        MISA     = 12'h301,
        MIE      = 12'h304,
        MTVEC    = 12'h305,
        MSCRATCH = 12'h340,
        MEPC     = 12'h341,
        MCAUSE   = 12'h342,
        MIP      = 12'h344
    } csr_addr_e;

    // RV32IM, MXL = 1
    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_1100;

    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INSTR = 32'd2;
    localparam logic [XLEN-1:0] CAUSE_ECALL_BASE    = 32'd8;
    localparam logic [XLEN-1:0] CAUSE_M_SOFT_INTR   = 32'h8000_0003;
    localparam logic [XLEN-1:0] CAUSE_M_TIMER_INTR  = 32'h8000_0007;
    localparam logic [XLEN-1:0] CAUSE_M_EXT_INTR    = 32'h8000_000b;

    // mstatus fields
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LO   = 11;
    localparam int MSTATUS_MPP_HI   = 12;

    // Same positions in mie and mip
    localparam int MIE_MSIE_BIT = 3;
    localparam int MIE_MTIE_BIT = 7;
    localparam int MIE_MEIE_BIT = 11;

    typedef enum logic [1:0] {
        TVEC_DIRECT   = 2'b00,
        TVEC_VECTORED = 2'b01
    } tvec_mode_e;

    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic [XLEN-3:0] base;
            tvec_mode_e      mode;
        } tvec;
    } csr_word_u;

    typedef struct packed {
        csr_cmd_e              cmd;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       operand;
        logic [XLEN-1:0]       pc;
    } csr_req_t;

    typedef struct packed {
        logic [XLEN-1:0] rdata;
        logic            trap;
        logic            redirect;
        logic [XLEN-1:0] target;
    } csr_rsp_t;

    typedef enum logic [1:0] {
        COMMIT_NONE  = 2'd0,
        COMMIT_WRITE = 2'd1,
        COMMIT_TRAP  = 2'd2,
        COMMIT_MRET  = 2'd3
    } commit_e;

    typedef struct packed {
        logic            take;
        logic [XLEN-1:0] cause;
        logic [XLEN-1:0] vector;
    } trap_dec_t;

endpackage

//--- verilog/csr_sequencer.sv
module csr_sequencer import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst_i,

    input  logic            req_i,
    input  csr_req_t        req_data_i,
    input  logic [XLEN-1:0] rdata_i,
    input  priv_mode_e      mode_i,
    input  logic [XLEN-1:0] mepc_i,
    input  trap_dec_t       trap_dec_i,

    output logic            ack_o,
    output csr_rsp_t        rsp_o,
    output csr_req_t        held_req_o,
    output commit_e         commit_o,
    output logic            expt_o,
    output logic [XLEN-1:0] expt_cause_o
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_BUSY,
        SEQ_ACK
    } seq_state_e;

    seq_state_e state_q;
    seq_state_e state_d;

    logic       is_write;
    logic       is_ecall;
    logic       priv_fault;
    logic       mret_fault;
    logic       read_only;
    csr_rsp_t   rsp_d;

    // Privilege check on the held request
    always_comb begin
        is_write   = (held_req_o.cmd == CMD_W) || (held_req_o.cmd == CMD_S) ||
                     (held_req_o.cmd == CMD_C);
        is_ecall   = (held_req_o.cmd == CMD_ECALL);
        priv_fault = is_write && (held_req_o.addr[9:8] > mode_i);
        mret_fault = (held_req_o.cmd == CMD_MRET) && (mode_i != PRIV_M);
        read_only  = (held_req_o.addr[11:10] == 2'b11);

        expt_o       = priv_fault || mret_fault || is_ecall;
        expt_cause_o = is_ecall ? CAUSE_ECALL_BASE + {30'b0, mode_i} : CAUSE_ILLEGAL_INSTR;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE: if (req_i) state_d = SEQ_BUSY;
            SEQ_BUSY: state_d = SEQ_ACK;
            SEQ_ACK:  if (!req_i) state_d = SEQ_IDLE;
            default:  state_d = SEQ_IDLE;
        endcase
    end

    // Commit action and response, both used only in the busy cycle
    always_comb begin
        commit_o = COMMIT_NONE;
        rsp_d    = '0;
        if (trap_dec_i.take) begin
            rsp_d.trap     = 1'b1;
            rsp_d.redirect = 1'b1;
            rsp_d.target   = trap_dec_i.vector;
            if (state_q == SEQ_BUSY) commit_o = COMMIT_TRAP;
        end else if (held_req_o.cmd == CMD_MRET) begin
            rsp_d.redirect = 1'b1;
            rsp_d.target   = mepc_i;
            if (state_q == SEQ_BUSY) commit_o = COMMIT_MRET;
        end else begin
            // Old value, before the write lands
            rsp_d.rdata = rdata_i;
            if (state_q == SEQ_BUSY && is_write && !read_only) commit_o = COMMIT_WRITE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= SEQ_IDLE;
            rsp_o   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == SEQ_BUSY) rsp_o <= rsp_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == SEQ_IDLE && req_i) held_req_o <= req_data_i;
    end

    assign ack_o = (state_q == SEQ_ACK);

endmodule

//--- verilog/csr_regfile.sv
module csr_regfile import csr_pkg::*; (
    input  logic               clk,
    input  logic               rst_i,

    input  csr_req_t           held_req_i,
    input  commit_e            commit_i,
    input  trap_dec_t          trap_dec_i,

    input  logic               sw_irq_i,
    input  logic               ext_irq_i,
    input  logic [63:0]        mtime_i,
    input  logic [63:0]        mtimecmp_i,

    output logic [XLEN-1:0]    rdata_o,
    output priv_mode_e         mode_o,
    output logic               mstatus_mie_o,
    output logic [NUM_IRQ-1:0] mie_o,
    output logic [NUM_IRQ-1:0] mip_o,
    output csr_word_u          mtvec_o,
    output logic [XLEN-1:0]    mepc_o
);

    priv_mode_e      mode;
    logic            mstatus_mie;
    logic            mstatus_mpie;
    priv_mode_e      mstatus_mpp;
    logic [NUM_IRQ-1:0] mie;
    csr_word_u       mtvec;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;

    logic [XLEN-1:0] mstatus_word;
    logic [XLEN-1:0] mie_word;
    logic [XLEN-1:0] mip_word;
    csr_word_u       wdata;

    // Pending bits follow the input levels directly
    always_comb begin
        mip_o            = '0;
        mip_o[IRQ_SOFT]  = sw_irq_i;
        mip_o[IRQ_TIMER] = (mtime_i >= mtimecmp_i);
        mip_o[IRQ_EXT]   = ext_irq_i;
    end

    always_comb begin
        mstatus_word                                = '0;
        mstatus_word[MSTATUS_MIE_BIT]               = mstatus_mie;
        mstatus_word[MSTATUS_MPIE_BIT]              = mstatus_mpie;
        mstatus_word[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = mstatus_mpp;

        mie_word               = '0;
        mie_word[MIE_MSIE_BIT] = mie[IRQ_SOFT];
        mie_word[MIE_MTIE_BIT] = mie[IRQ_TIMER];
        mie_word[MIE_MEIE_BIT] = mie[IRQ_EXT];

        mip_word               = '0;
        mip_word[MIE_MSIE_BIT] = mip_o[IRQ_SOFT];
        mip_word[MIE_MTIE_BIT] = mip_o[IRQ_TIMER];
        mip_word[MIE_MEIE_BIT] = mip_o[IRQ_EXT];
    end

    // Read mux, unimplemented addresses read as zero
    always_comb begin
        case (held_req_i.addr)
            MSTATUS:  rdata_o = mstatus_word;
            MISA:     rdata_o = MISA_VALUE;
            MIE:      rdata_o = mie_word;
            MTVEC:    rdata_o = mtvec.raw;
            MSCRATCH: rdata_o = mscratch;
            MEPC:     rdata_o = mepc;
            MCAUSE:   rdata_o = mcause;
            MIP:      rdata_o = mip_word;
            default:  rdata_o = '0;
        endcase
    end

    always_comb begin
        case (held_req_i.cmd)
            CMD_W:   wdata.raw = held_req_i.operand;
            CMD_S:   wdata.raw = rdata_o | held_req_i.operand;
            CMD_C:   wdata.raw = rdata_o & ~held_req_i.operand;
            default: wdata.raw = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mode         <= PRIV_M;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_U;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else begin
            case (commit_i)
                COMMIT_WRITE: begin
                    case (held_req_i.addr)
                        MSTATUS: begin
                            mstatus_mie  <= wdata.raw[MSTATUS_MIE_BIT];
                            mstatus_mpie <= wdata.raw[MSTATUS_MPIE_BIT];
                            // Only M and U exist, anything but 2'b11 lands in U
                            mstatus_mpp  <= (wdata.raw[MSTATUS_MPP_HI:MSTATUS_MPP_LO] == 2'b11) ?
                                            PRIV_M : PRIV_U;
                        end
                        MIE: begin
                            mie[IRQ_SOFT]  <= wdata.raw[MIE_MSIE_BIT];
                            mie[IRQ_TIMER] <= wdata.raw[MIE_MTIE_BIT];
                            mie[IRQ_EXT]   <= wdata.raw[MIE_MEIE_BIT];
                        end
                        MTVEC: begin
                            mtvec.tvec.base <= wdata.tvec.base;
                            mtvec.tvec.mode <= wdata.tvec.mode[0] ? TVEC_VECTORED : TVEC_DIRECT;
                        end
                        MSCRATCH: mscratch <= wdata.raw;
                        MEPC:     mepc     <= {wdata.raw[XLEN-1:2], 2'b00};
                        MCAUSE:   mcause   <= wdata.raw;
                        default: begin
                        end
                    endcase
                end
                COMMIT_TRAP: begin
                    mepc         <= held_req_i.pc;
                    mcause       <= trap_dec_i.cause;
                    mstatus_mpie <= mstatus_mie;
                    mstatus_mie  <= 1'b0;
                    mstatus_mpp  <= mode;
                    mode         <= PRIV_M;
                end
                COMMIT_MRET: begin
                    mode         <= mstatus_mpp;
                    mstatus_mie  <= mstatus_mpie;
                    mstatus_mpie <= 1'b1;
                    mstatus_mpp  <= PRIV_U;
                end
                default: begin
                end
            endcase
        end
    end

    assign mode_o        = mode;
    assign mstatus_mie_o = mstatus_mie;
    assign mie_o         = mie;
    assign mtvec_o       = mtvec;
    assign mepc_o        = mepc;

endmodule

//--- verilog/csr_trap_ctrl.sv
module csr_trap_ctrl import csr_pkg::*; (
    input  logic               expt_i,
    input  logic [XLEN-1:0]    expt_cause_i,
    input  priv_mode_e         mode_i,
    input  logic               mstatus_mie_i,
    input  logic [NUM_IRQ-1:0] mie_i,
    input  logic [NUM_IRQ-1:0] mip_i,
    input  csr_word_u          mtvec_i,

    output trap_dec_t          trap_dec_o
);

    logic               global_en;
    logic [NUM_IRQ-1:0] active;
    logic [XLEN-1:0]    intr_cause;
    logic [XLEN-1:0]    base;

    // U-mode can always be interrupted by M-level sources
    always_comb begin
        global_en = (mode_i == PRIV_U) || mstatus_mie_i;
        active    = mie_i & mip_i & {NUM_IRQ{global_en}};
    end

    // External, then software, then timer
    always_comb begin
        if (active[IRQ_EXT]) begin
            intr_cause = CAUSE_M_EXT_INTR;
        end else if (active[IRQ_SOFT]) begin
            intr_cause = CAUSE_M_SOFT_INTR;
        end else if (active[IRQ_TIMER]) begin
            intr_cause = CAUSE_M_TIMER_INTR;
        end else begin
            intr_cause = '0;
        end
    end

    always_comb begin
        base = {mtvec_i.tvec.base, 2'b00};

        trap_dec_o.take  = expt_i || (|active);
        trap_dec_o.cause = expt_i ? expt_cause_i : intr_cause;

        // Exceptions always go to the base
        if (!expt_i && mtvec_i.tvec.mode == TVEC_VECTORED) begin
            trap_dec_o.vector = base + {intr_cause[XLEN-3:0], 2'b00};
        end else begin
            trap_dec_o.vector = base;
        end
    end

endmodule

//--- verilog/csr_unit_top.sv
module csr_unit_top import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,

    input  logic        req_i,
    input  csr_req_t    req_data_i,

    input  logic        sw_irq_i,
    input  logic        ext_irq_i,
    input  logic [63:0] mtime_i,
    input  logic [63:0] mtimecmp_i,

    output logic        ack_o,
    output csr_rsp_t    rsp_o,
    output priv_mode_e  priv_mode_o
);

    csr_req_t              held_req;
    commit_e               commit;
    logic [XLEN-1:0]       rdata;
    logic [XLEN-1:0]       mepc;
    logic                  mstatus_mie;
    logic [NUM_IRQ-1:0]    mie;
    logic [NUM_IRQ-1:0]    mip;
    csr_word_u             mtvec;
    logic                  expt;
    logic [XLEN-1:0]       expt_cause;
    trap_dec_t             trap_dec;

    csr_sequencer csr_sequencer_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .req_data_i   (req_data_i),
        .rdata_i      (rdata),
        .mode_i       (priv_mode_o),
        .mepc_i       (mepc),
        .trap_dec_i   (trap_dec),
        .ack_o        (ack_o),
        .rsp_o        (rsp_o),
        .held_req_o   (held_req),
        .commit_o     (commit),
        .expt_o       (expt),
        .expt_cause_o (expt_cause)
    );

    csr_regfile csr_regfile_inst (
        .clk           (clk),
        .rst_i         (rst_i),
        .held_req_i    (held_req),
        .commit_i      (commit),
        .trap_dec_i    (trap_dec),
        .sw_irq_i      (sw_irq_i),
        .ext_irq_i     (ext_irq_i),
        .mtime_i       (mtime_i),
        .mtimecmp_i    (mtimecmp_i),
        .rdata_o       (rdata),
        .mode_o        (priv_mode_o),
        .mstatus_mie_o (mstatus_mie),
        .mie_o         (mie),
        .mip_o         (mip),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc)
    );

    csr_trap_ctrl csr_trap_ctrl_inst (
        .expt_i        (expt),
        .expt_cause_i  (expt_cause),
        .mode_i        (priv_mode_o),
        .mstatus_mie_i (mstatus_mie),
        .mie_i         (mie),
        .mip_i         (mip),
        .mtvec_i       (mtvec),
        .trap_dec_o    (trap_dec)
    );

endmodule

//--- verification/csr_unit_properties.sv
module csr_unit_properties import csr_pkg::*; (
    input logic     clk,
    input logic     rst_i,
    input logic     req_i,
    input logic     ack_i,
    input csr_rsp_t rsp_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Rise is seen one edge late, so look at req on the edge before
    assert property (@(posedge clk) disable iff (rst_i) $rose(ack_i) |-> $past(req_i))
        else begin
            fail_count++;
            $error("ack rose while req was low");
        end

    // Held until the requester lets go
    assert property (@(posedge clk) disable iff (rst_i) ack_i && req_i |=> ack_i)
        else begin
            fail_count++;
            $error("ack dropped while req was still high");
        end

    assert property (@(posedge clk) disable iff (rst_i) ack_i && !req_i |=> !ack_i)
        else begin
            fail_count++;
            $error("ack stayed high after req fell");
        end

    assert property (@(posedge clk) disable iff (rst_i) $past(ack_i) && ack_i |-> $stable(rsp_i))
        else begin
            fail_count++;
            $error("rsp changed while ack was high");
        end

    // Request seen at E0, ack visible two edges later
    assert property (@(posedge clk) disable iff (rst_i)
                     $rose(req_i) && !ack_i |-> !ack_i ##1 !ack_i ##1 ack_i)
        else begin
            fail_count++;
            $error("ack did not follow the accepted req by two edges");
        end

endmodule

bind csr_sequencer csr_unit_properties csr_unit_properties_inst (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (req_i),
    .ack_i (ack_o),
    .rsp_i (rsp_o)
);

//--- verification/csr_unit_tb.sv
module csr_unit_tb import csr_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam string PATTERN_FILE = "verification/csr_patterns.txt";

    // One transaction, stimulus then expected response
    typedef struct packed {
        csr_req_t        req;
        logic            sw_irq;
        logic            ext_irq;
        logic [63:0]     mtime;
        logic [63:0]     mtimecmp;
        logic            exp_trap;
        logic            exp_redirect;
        logic [XLEN-1:0] exp_target;
        logic [XLEN-1:0] exp_rdata;
        logic [1:0]      exp_mode;
    } pattern_t;

    logic        clk;
    logic        rst_i;
    logic        req_i;
    csr_req_t    req_data_i;
    logic        sw_irq_i;
    logic        ext_irq_i;
    logic [63:0] mtime_i;
    logic [63:0] mtimecmp_i;
    logic        ack_o;
    csr_rsp_t    rsp_o;
    priv_mode_e  priv_mode_o;

    pattern_t    patterns[$];
    int          error_count;
    int          check_count;
    int          cycle_count;
    int          timeout_limit;
    int          prop_failures;
    bit          load_ok;

    csr_unit_top csr_unit_top_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (req_i),
        .req_data_i  (req_data_i),
        .sw_irq_i    (sw_irq_i),
        .ext_irq_i   (ext_irq_i),
        .mtime_i     (mtime_i),
        .mtimecmp_i  (mtimecmp_i),
        .ack_o       (ack_o),
        .rsp_o       (rsp_o),
        .priv_mode_o (priv_mode_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles, the handshake never completed", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic load_patterns(output bit ok);
        int              fd;
        int              fields;
        int              line_no;
        string           line;
        logic [31:0]     cmd_v, addr_v, sw_v, ext_v, trap_v, redir_v, mode_v;
        logic [XLEN-1:0] operand_v, pc_v, target_v, rdata_v;
        logic [63:0]     mtime_v, mtimecmp_v;
        pattern_t        pat;
        ok      = 1'b1;
        line_no = 0;
        fd      = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file %s", PATTERN_FILE);
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                line_no++;
                // Blank lines and comment lines carry no transaction
                if (line.len() > 1 && line[0] != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                     cmd_v, addr_v, operand_v, pc_v, sw_v, ext_v,
                                     mtime_v, mtimecmp_v, trap_v, redir_v,
                                     target_v, rdata_v, mode_v);
                    if (fields != 13) begin
                        $display("Malformed line %0d in %s", line_no, PATTERN_FILE);
                        ok = 1'b0;
                    end else begin
                        pat.req.cmd      = csr_cmd_e'(cmd_v[2:0]);
                        pat.req.addr     = addr_v[CSR_ADDR_W-1:0];
                        pat.req.operand  = operand_v;
                        pat.req.pc       = pc_v;
                        pat.sw_irq       = sw_v[0];
                        pat.ext_irq      = ext_v[0];
                        pat.mtime        = mtime_v;
                        pat.mtimecmp     = mtimecmp_v;
                        pat.exp_trap     = trap_v[0];
                        pat.exp_redirect = redir_v[0];
                        pat.exp_target   = target_v;
                        pat.exp_rdata    = rdata_v;
                        pat.exp_mode     = mode_v[1:0];
                        patterns.push_back(pat);
                    end
                end
            end
            $fclose(fd);
            if (patterns.size() == 0) begin
                $display("The pattern file %s holds no transactions", PATTERN_FILE);
                ok = 1'b0;
            end
        end
    endtask

    task automatic check_field(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual, input int index);
        check_count++;
        assert (actual === expected)
            else begin
                error_count++;
                $display("ERR %0t %s expected %h actual %h (pattern %0d)",
                         $time, name, expected, actual, index);
            end
    endtask

    // Sample 1 ns after each edge, away from the DUT's own updates
    task automatic wait_for_ack(input logic level);
        do begin
            @(posedge clk);
            #1;
        end while (ack_o !== level);
    endtask

    task automatic run_transaction(input pattern_t pat, input int index);
        req_data_i = pat.req;
        sw_irq_i   = pat.sw_irq;
        ext_irq_i  = pat.ext_irq;
        mtime_i    = pat.mtime;
        mtimecmp_i = pat.mtimecmp;
        req_i      = 1'b1;
        wait_for_ack(1'b1);
        check_field("rsp_o.trap", pat.exp_trap, rsp_o.trap, index);
        check_field("rsp_o.redirect", pat.exp_redirect, rsp_o.redirect, index);
        check_field("rsp_o.target", pat.exp_target, rsp_o.target, index);
        check_field("rsp_o.rdata", pat.exp_rdata, rsp_o.rdata, index);
        check_field("priv_mode_o", pat.exp_mode, priv_mode_o, index);
        // Requester back-pressure on some transactions
        repeat (index % 3) begin
            @(posedge clk);
            #1;
            check_field("ack_o", 1'b1, ack_o, index);
        end
        req_i = 1'b0;
        wait_for_ack(1'b0);
    endtask

    initial begin
        clk        = 1'b0;
        rst_i      = 1'b1;
        req_i      = 1'b0;
        req_data_i = '0;
        sw_irq_i   = 1'b0;
        ext_irq_i  = 1'b0;
        mtime_i    = '0;
        mtimecmp_i = '1;
        load_patterns(load_ok);
        if (load_ok) begin
            timeout_limit = patterns.size() * 8 + 50;
            repeat (4) @(posedge clk);
            #1;
            rst_i = 1'b0;
            foreach (patterns[i]) begin
                run_transaction(patterns[i], i);
            end
        end
        prop_failures = csr_unit_top_inst.csr_sequencer_inst.csr_unit_properties_inst.fail_count;
        $display("Transactions %0d, checks %0d, errors %0d, property failures %0d",
                 patterns.size(), check_count, error_count, prop_failures);
        if (load_ok && error_count == 0 && prop_failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- list.f
verilog/csr_pkg.sv
verilog/csr_sequencer.sv
verilog/csr_regfile.sv
verilog/csr_trap_ctrl.sv
verilog/csr_unit_top.sv
verification/csr_unit_properties.sv
verification/csr_unit_tb.sv

//--- verification/csr_patterns.txt
# cmd addr operand pc sw ext mtime mtimecmp, then expected trap redirect target rdata mode
# cmd: 0 read, 1 write, 2 set, 3 clear, 4 ecall, 5 mret; all fields hex
# Reset values
0 300 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000000 3
0 305 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000000 3
0 340 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000000 3
0 301 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 40001100 3
0 7c0 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000000 3
# mscratch write, set, clear
1 340 a5a5a5a5 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000000 3
2 340 0f0f0000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 a5a5a5a5 3
3 340 000000ff 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 afafa5a5 3
0 340 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 afafa500 3
# mie write, set, clear
1 304 00000008 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000000 3
2 304 00000880 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000008 3
3 304 00000088 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000888 3
0 304 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000800 3
# mepc drops bits 1:0
1 341 00001237 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000000 3
0 341 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00001234 3
# ECALL from M, direct mtvec
1 305 00000100 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000000 3
4 000 00000000 00000200 0 0 0000000000000000 ffffffffffffffff 1 1 00000100 00000000 3
0 342 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 0000000b 3
0 341 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000200 3
0 300 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00001800 3
# MRET into U, then U-mode faults
1 300 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00001800 3
5 000 00000000 00000204 0 0 0000000000000000 ffffffffffffffff 0 1 00000200 00000000 0
1 340 00000001 00000300 0 0 0000000000000000 ffffffffffffffff 1 1 00000100 00000000 3
0 342 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000002 3
5 000 00000000 00000304 0 0 0000000000000000 ffffffffffffffff 0 1 00000300 00000000 0
4 000 00000000 00000400 0 0 0000000000000000 ffffffffffffffff 1 1 00000100 00000000 3
0 342 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000008 3
5 000 00000000 00000404 0 0 0000000000000000 ffffffffffffffff 0 1 00000400 00000000 0
5 000 00000000 00000500 0 0 0000000000000000 ffffffffffffffff 1 1 00000100 00000000 3
0 342 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000002 3
# Vectored interrupts, base 0x100
1 305 00000101 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000100 3
1 304 00000888 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000800 3
1 300 00000008 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00000000 3
0 340 00000000 00000600 1 1 0000000000000000 ffffffffffffffff 1 1 0000012c 00000000 3
1 300 00000008 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00001880 3
0 340 00000000 00000604 1 0 0000000000000000 ffffffffffffffff 1 1 0000010c 00000000 3
1 300 00000008 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 00001880 3
0 340 00000000 00000608 0 0 0000000000000010 0000000000000010 1 1 0000011c 00000000 3
# All pending but MIE clear in M
0 342 00000000 00000000 1 1 0000000000000020 0000000000000010 0 0 00000000 80000007 3
# misa ignores writes
1 301 ffffffff 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 40001100 3
0 301 00000000 00000000 0 0 0000000000000000 ffffffffffffffff 0 0 00000000 40001100 3
